// ==== design/gpio_pkg.sv ====
/*
 * GPIO peripheral shared definitions
 * Pin count, bus widths, register map and the
 * structs passed between the bus controller and the datapath
 */

`default_nettype none

package gpio_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Number of GPIO pins
    localparam int unsigned GPIO_W     = 32;
    // Bus data width, never below GPIO_W
    localparam int unsigned BUS_DW     = 32;
    // Register address width
    localparam int unsigned ADR_W      = 3;
    // Input synchronizer depth
    localparam int unsigned CDC_STAGES = 2;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    localparam logic [ADR_W-1:0] REG_OUT  = 3'd0;  // output data
    localparam logic [ADR_W-1:0] REG_OE   = 3'd1;  // output enable
    localparam logic [ADR_W-1:0] REG_IN   = 3'd2;  // synchronized input, read only
    localparam logic [ADR_W-1:0] REG_IEN  = 3'd3;  // input enable
    localparam logic [ADR_W-1:0] REG_RISE = 3'd4;  // rising edge irq enable
    localparam logic [ADR_W-1:0] REG_FALL = 3'd5;  // falling edge irq enable
    localparam logic [ADR_W-1:0] REG_STS  = 3'd6;  // irq status, write one to clear
    localparam logic [ADR_W-1:0] REG_TGL  = 3'd7;  // toggle port for output data

    // All inputs enabled out of reset
    localparam logic [GPIO_W-1:0] IEN_RESET = '1;

    //////////////////////////////////////////////////
    // Bus request and response
    //////////////////////////////////////////////////

    typedef struct packed {
        logic              wen;
        logic              ren;
        logic [ADR_W-1:0]  adr;
        logic [BUS_DW-1:0] wdt;
    } bus_req_t;

    typedef struct packed {
        logic [BUS_DW-1:0] rdt;
        logic              err;
    } bus_rsp_t;

    //////////////////////////////////////////////////
    // Controller to datapath
    //////////////////////////////////////////////////

    // One strobe per writable register
    typedef struct packed {
        logic              out_we;
        logic              tgl_we;
        logic              oe_we;
        logic              ien_we;
        logic              rise_we;
        logic              fall_we;
        logic              sts_clr;
        logic [GPIO_W-1:0] dat;
    } gpio_wr_t;

    // Register values returned for reads
    typedef struct packed {
        logic [GPIO_W-1:0] out;
        logic [GPIO_W-1:0] oe;
        logic [GPIO_W-1:0] in;
        logic [GPIO_W-1:0] ien;
        logic [GPIO_W-1:0] rise;
        logic [GPIO_W-1:0] fall;
        logic [GPIO_W-1:0] sts;
    } gpio_state_t;

endpackage : gpio_pkg

`default_nettype wire

// ==== design/gpio_bus_ctrl.sv ====
/*
 * GPIO bus controller
 * Decodes single-cycle bus transfers into register write strobes
 * and returns read data with zero delay
 */

`timescale 1ns/1ps
`default_nettype none

module gpio_bus_ctrl
    import gpio_pkg::*;
(
    // Bus side
    input  logic        trn,
    input  bus_req_t    req,
    output bus_rsp_t    rsp,
    // Datapath side
    input  gpio_state_t state,
    output gpio_wr_t    wr
);

    //////////////////////////////////////////////////
    // Transfer qualification
    //////////////////////////////////////////////////

    logic              bus_wr;
    logic              bus_rd;
    logic [GPIO_W-1:0] rd_word;

    // Strobes only count inside a transfer
    assign bus_wr = trn & req.wen;
    assign bus_rd = trn & req.ren;

    //////////////////////////////////////////////////
    // Write decode
    //////////////////////////////////////////////////

    always_comb begin
        // Default to no strobe
        wr.out_we  = 1'b0;
        wr.tgl_we  = 1'b0;
        wr.oe_we   = 1'b0;
        wr.ien_we  = 1'b0;
        wr.rise_we = 1'b0;
        wr.fall_we = 1'b0;
        wr.sts_clr = 1'b0;
        // Pins take the low bits of the bus word
        wr.dat     = req.wdt[GPIO_W-1:0];
        if (bus_wr) begin
            case (req.adr)
                REG_OUT: begin
                    wr.out_we = 1'b1;
                end
                REG_OE: begin
                    wr.oe_we = 1'b1;
                end
                REG_IEN: begin
                    wr.ien_we = 1'b1;
                end
                REG_RISE: begin
                    wr.rise_we = 1'b1;
                end
                REG_FALL: begin
                    wr.fall_we = 1'b1;
                end
                REG_STS: begin
                    wr.sts_clr = 1'b1;
                end
                REG_TGL: begin
                    wr.tgl_we = 1'b1;
                end
                // Input register is read only, no strobe
                default: begin
                    wr.out_we = 1'b0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Read multiplexer
    //////////////////////////////////////////////////

    always_comb begin
        case (req.adr)
            REG_OUT:  rd_word = state.out;
            REG_OE:   rd_word = state.oe;
            REG_IN:   rd_word = state.in;
            REG_IEN:  rd_word = state.ien;
            REG_RISE: rd_word = state.rise;
            REG_FALL: rd_word = state.fall;
            REG_STS:  rd_word = state.sts;
            // Toggle address reads back output data
            REG_TGL:  rd_word = state.out;
            default:  rd_word = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    // Zero outside a read, extended to bus width
    assign rsp.rdt = bus_rd ? BUS_DW'(rd_word) : '0;

    // Write into the input register is rejected
    assign rsp.err = bus_wr & (req.adr == REG_IN);

endmodule : gpio_bus_ctrl

`default_nettype wire

// ==== design/gpio_in_sync.sv ====
/*
 * GPIO input path
 * Synchronizer chain for asynchronous pins
 * and the per-pin input enable register
 */

`timescale 1ns/1ps
`default_nettype none

module gpio_in_sync
    import gpio_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // Raw pins
    input  logic [GPIO_W-1:0] gpio_i,
    // Register writes
    input  gpio_wr_t          wr,
    // Register and synchronized input
    output logic [GPIO_W-1:0] ien,
    output logic [GPIO_W-1:0] in_sync
);

    //////////////////////////////////////////////////
    // Synchronizer
    //////////////////////////////////////////////////

    // Stage 0 samples the pins, last stage is stable
    logic [CDC_STAGES-1:0][GPIO_W-1:0] sync_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            // Shift towards the last stage
            sync_q <= {sync_q[CDC_STAGES-2:0], gpio_i};
        end
    end

    //////////////////////////////////////////////////
    // Input enable
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ien <= IEN_RESET;
        end else if (wr.ien_we) begin
            ien <= wr.dat;
        end
    end

    // Disabled pins read zero and raise no edges
    assign in_sync = sync_q[CDC_STAGES-1] & ien;

endmodule : gpio_in_sync

`default_nettype wire

// ==== design/gpio_out_port.sv ====
/*
 * GPIO output port
 * Output data and output enable registers,
 * data takes plain loads and per-bit toggles
 */

`timescale 1ns/1ps
`default_nettype none

module gpio_out_port
    import gpio_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // Register writes
    input  gpio_wr_t          wr,
    // Pin drivers
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_e
);

    //////////////////////////////////////////////////
    // Output data
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_o <= '0;
        end else if (wr.out_we) begin
            // Plain load
            gpio_o <= wr.dat;
        end else if (wr.tgl_we) begin
            // Flip pins where data is one
            gpio_o <= gpio_o ^ wr.dat;
        end
    end

    //////////////////////////////////////////////////
    // Output enable
    //////////////////////////////////////////////////

    // Pins start as inputs
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_e <= '0;
        end else if (wr.oe_we) begin
            gpio_e <= wr.dat;
        end
    end

endmodule : gpio_out_port

`default_nettype wire

// ==== design/gpio_irq_unit.sv ====
/*
 * GPIO interrupt unit
 * Per-pin edge detection with rise and fall enables,
 * sticky write-one-to-clear status and a level interrupt
 */

`timescale 1ns/1ps
`default_nettype none

module gpio_irq_unit
    import gpio_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // Synchronized, enabled input
    input  logic [GPIO_W-1:0] in_sync,
    // Register writes
    input  gpio_wr_t          wr,
    // Registers for read back
    output logic [GPIO_W-1:0] rise,
    output logic [GPIO_W-1:0] fall,
    output logic [GPIO_W-1:0] sts,
    // Level interrupt
    output logic              irq
);

    logic [GPIO_W-1:0] in_prev;
    logic [GPIO_W-1:0] evt_rise;
    logic [GPIO_W-1:0] evt_fall;
    logic [GPIO_W-1:0] clr_mask;

    //////////////////////////////////////////////////
    // Edge enables
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rise <= '0;
            fall <= '0;
        end else begin
            if (wr.rise_we) begin
                rise <= wr.dat;
            end
            if (wr.fall_we) begin
                fall <= wr.dat;
            end
        end
    end

    //////////////////////////////////////////////////
    // Edge detection
    //////////////////////////////////////////////////

    // History of the synchronized input
    always_ff @(posedge clk) begin
        if (rst) begin
            in_prev <= '0;
        end else begin
            in_prev <= in_sync;
        end
    end

    // Masked edge events
    assign evt_rise = in_sync & ~in_prev & rise;
    assign evt_fall = ~in_sync & in_prev & fall;

    //////////////////////////////////////////////////
    // Status and interrupt
    //////////////////////////////////////////////////

    // Bits picked for clearing by this write
    assign clr_mask = wr.sts_clr ? wr.dat : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            sts <= '0;
            irq <= 1'b0;
        end else begin
            // Set after clear so a new edge wins
            sts <= (sts & ~clr_mask) | evt_rise | evt_fall;
            // One edge behind status
            irq <= |sts;
        end
    end

endmodule : gpio_irq_unit

`default_nettype wire

// ==== design/gpio_peri_top.sv ====
/*
 * GPIO peripheral top level
 * Bus controller plus output, input and interrupt datapath
 */

`timescale 1ns/1ps
`default_nettype none

module gpio_peri_top
    import gpio_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // Bus
    input  logic              trn,
    input  bus_req_t          req,
    output bus_rsp_t          rsp,
    // Pins
    output logic [GPIO_W-1:0] gpio_o,
    output logic [GPIO_W-1:0] gpio_e,
    input  logic [GPIO_W-1:0] gpio_i,
    // Interrupt
    output logic              irq
);

    gpio_wr_t          wr;
    gpio_state_t       state;
    logic [GPIO_W-1:0] ien;
    logic [GPIO_W-1:0] in_sync;
    logic [GPIO_W-1:0] rise;
    logic [GPIO_W-1:0] fall;
    logic [GPIO_W-1:0] sts;

    //////////////////////////////////////////////////
    // Register state for reads
    //////////////////////////////////////////////////

    assign state.out  = gpio_o;
    assign state.oe   = gpio_e;
    assign state.in   = in_sync;
    assign state.ien  = ien;
    assign state.rise = rise;
    assign state.fall = fall;
    assign state.sts  = sts;

    //////////////////////////////////////////////////
    // Instances
    //////////////////////////////////////////////////

    gpio_bus_ctrl i_bus_ctrl (
        .trn     (trn),
        .req     (req),
        .rsp     (rsp),
        .state   (state),
        .wr      (wr)
    );

    gpio_out_port i_out_port (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .gpio_o  (gpio_o),
        .gpio_e  (gpio_e)
    );

    gpio_in_sync i_in_sync (
        .clk     (clk),
        .rst     (rst),
        .gpio_i  (gpio_i),
        .wr      (wr),
        .ien     (ien),
        .in_sync (in_sync)
    );

    gpio_irq_unit i_irq_unit (
        .clk     (clk),
        .rst     (rst),
        .in_sync (in_sync),
        .wr      (wr),
        .rise    (rise),
        .fall    (fall),
        .sts     (sts),
        .irq     (irq)
    );

endmodule : gpio_peri_top

`default_nettype wire

// ==== testbench/gpio_tb.sv ====
/*
 * GPIO peripheral testbench
 * Bus tasks, random pin stimulus and a register model
 * compared with the DUT on every falling edge
 */

`timescale 1ns/1ps
`default_nettype none

module gpio_tb
    import gpio_pkg::*;
();

    logic              clk;
    logic              rst;
    logic              trn;
    bus_req_t          req;
    bus_rsp_t          rsp;
    logic [GPIO_W-1:0] gpio_o;
    logic [GPIO_W-1:0] gpio_e;
    logic [GPIO_W-1:0] gpio_i;
    logic              irq;

    // Model state where in holds the raw last sync stage
    gpio_state_t       exp_st;
    logic [GPIO_W-1:0] sync1;
    logic [GPIO_W-1:0] prev;
    logic [GPIO_W-1:0] in_now;
    logic [GPIO_W-1:0] clr;
    logic              exp_irq;
    int                n_pass = 0;
    int                n_fail = 0;
    int                test_base = 0;

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    gpio_peri_top i_dut (
        .clk    (clk),
        .rst    (rst),
        .trn    (trn),
        .req    (req),
        .rsp    (rsp),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i),
        .irq    (irq)
    );

    //////////////////////////////////////////////////
    // Register model
    //////////////////////////////////////////////////

    assign in_now = exp_st.in & exp_st.ien;
    assign clr    = (trn && req.wen && req.adr == REG_STS) ? req.wdt[GPIO_W-1:0] : '0;

    always @(posedge clk) begin
        if (rst) begin
            exp_st     <= '0;
            exp_st.ien <= IEN_RESET;
            sync1      <= '0;
            prev       <= '0;
            exp_irq    <= 1'b0;
        end else begin
            // Two sync edges then status then irq
            sync1      <= gpio_i;
            exp_st.in  <= sync1;
            prev       <= in_now;
            exp_st.sts <= (exp_st.sts & ~clr) | (in_now & ~prev & exp_st.rise)
                          | (~in_now & prev & exp_st.fall);
            exp_irq    <= |exp_st.sts;
            if (trn && req.wen) begin
                case (req.adr)
                    REG_OUT:  exp_st.out  <= req.wdt[GPIO_W-1:0];
                    REG_OE:   exp_st.oe   <= req.wdt[GPIO_W-1:0];
                    REG_IEN:  exp_st.ien  <= req.wdt[GPIO_W-1:0];
                    REG_RISE: exp_st.rise <= req.wdt[GPIO_W-1:0];
                    REG_FALL: exp_st.fall <= req.wdt[GPIO_W-1:0];
                    REG_TGL:  exp_st.out  <= exp_st.out ^ req.wdt[GPIO_W-1:0];
                    default: begin
                    end
                endcase
            end
        end
    end

    // Expected read word per address
    function automatic logic [GPIO_W-1:0] reg_value(input logic [ADR_W-1:0] adr);
        case (adr)
            REG_OUT, REG_TGL: return exp_st.out;
            REG_OE:           return exp_st.oe;
            REG_IN:           return in_now;
            REG_IEN:          return exp_st.ien;
            REG_RISE:         return exp_st.rise;
            REG_FALL:         return exp_st.fall;
            default:          return exp_st.sts;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Checks and bus tasks
    //////////////////////////////////////////////////

    task automatic check_eq(input string what, input logic [BUS_DW-1:0] got,
                            input logic [BUS_DW-1:0] exp);
        assert (got === exp) n_pass++;
        else begin
            n_fail++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Ports and same-cycle response sampled mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            check_eq("gpio_o", gpio_o, exp_st.out);
            check_eq("gpio_e", gpio_e, exp_st.oe);
            check_eq("irq", irq, exp_irq);
            check_eq("rsp.err", rsp.err, trn && req.wen && req.adr == REG_IN);
            check_eq("rsp.rdt", rsp.rdt, (trn && req.ren) ? reg_value(req.adr) : '0);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $finish;
    endtask

    // Tasks start and end 1 ns after a rising edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [BUS_DW-1:0] dat,
                             output logic err);
        trn = 1'b1;
        req = '{wen: 1'b1, ren: 1'b0, adr: adr, wdt: dat};
        #3 err = rsp.err;
        step(1);
        trn = 1'b0;
        req = '0;
    endtask

    task automatic bus_read(input logic [ADR_W-1:0] adr, output logic [BUS_DW-1:0] dat);
        trn = 1'b1;
        req = '{wen: 1'b0, ren: 1'b1, adr: adr, wdt: '0};
        #3 dat = rsp.rdt;
        step(1);
        trn = 1'b0;
        req = '0;
    endtask

    // Counts edges until irq reaches level
    task automatic wait_irq(input logic level, output int edges);
        edges = 0;
        while (irq !== level) begin
            step(1);
            edges++;
            if (edges > 10) begin
                abort_run("timeout, irq never reached the expected level");
            end
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-10s done, %0d errors", name, n_fail - test_base);
        test_base = n_fail;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [BUS_DW-1:0] d;
        logic [BUS_DW-1:0] rd;
        logic [BUS_DW-1:0] pins;
        logic [BUS_DW-1:0] mask;
        logic [BUS_DW-1:0] en_r;
        logic              werr;
        int                edges;
        int                j;
        void'($urandom(32'hb6be));
        rst    = 1'b1;
        trn    = 1'b0;
        req    = '0;
        gpio_i = '0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // Reset values on ports and in every register
        check_eq("reset irq", irq, 1'b0);
        for (int a = 0; a < 8; a++) begin
            bus_read(ADR_W'(a), rd);
            check_eq("reset read", rd, (a == REG_IEN) ? IEN_RESET : '0);
        end
        finish_test("reset");

        repeat (8) begin
            d = $urandom();
            bus_write(REG_OUT, d, werr);
            check_eq("gpio_o after write", gpio_o, d);
            bus_read(REG_OUT, rd);
            check_eq("REG_OUT read", rd, d);
            bus_write(REG_OE, ~d, werr);
            bus_read(REG_OE, rd);
            check_eq("REG_OE read", rd, ~d);
            mask = $urandom();
            bus_write(REG_TGL, mask, werr);
            check_eq("gpio_o after toggle", gpio_o, d ^ mask);
        end
        finish_test("outputs");

        // Input enable masks the synchronized pins
        repeat (8) begin
            mask = $urandom();
            pins = $urandom();
            bus_write(REG_IEN, mask, werr);
            gpio_i = pins;
            step(2);
            bus_read(REG_IN, rd);
            check_eq("REG_IN", rd, pins & mask);
        end
        bus_write(REG_IN, $urandom(), werr);
        check_eq("err on REG_IN write", werr, 1'b1);
        bus_read(REG_IN, rd);
        check_eq("REG_IN after write", rd, pins & mask);
        finish_test("inputs");

        gpio_i = '0;
        bus_write(REG_IEN, '1, werr);
        step(3);
        repeat (4) begin
            en_r = $urandom() | 32'h1;
            d    = $urandom();
            pins = $urandom() | 32'h1;
            bus_write(REG_RISE, en_r, werr);
            bus_write(REG_FALL, d, werr);
            gpio_i = pins;
            wait_irq(1'b1, edges);
            check_eq("edges to irq", edges, 4);
            bus_read(REG_STS, rd);
            check_eq("status after rise", rd, pins & en_r);
            gpio_i = '0;
            step(4);
            bus_read(REG_STS, rd);
            check_eq("status after fall", rd, pins & (en_r | d));
            bus_write(REG_STS, '1, werr);
            wait_irq(1'b0, edges);
        end
        // Pins disabled by REG_IEN and then by the edge enables
        mask = $urandom();
        bus_write(REG_IEN, mask, werr);
        bus_write(REG_RISE, '1, werr);
        bus_write(REG_FALL, '1, werr);
        gpio_i = ~mask;
        step(4);
        gpio_i = '0;
        step(4);
        bus_write(REG_IEN, '1, werr);
        bus_write(REG_RISE, '0, werr);
        bus_write(REG_FALL, '0, werr);
        gpio_i = $urandom();
        step(4);
        bus_read(REG_STS, rd);
        check_eq("status of disabled pins", rd, '0);
        finish_test("edges");

        bus_write(REG_RISE, '1, werr);
        bus_write(REG_FALL, '1, werr);
        gpio_i = '0;
        step(4);
        // Drop the status left by the falling pins
        bus_write(REG_STS, '1, werr);
        wait_irq(1'b0, edges);
        pins = $urandom() | 32'h1;
        gpio_i = pins;
        wait_irq(1'b1, edges);
        // Bit 0 stays set so irq holds through the partial clear
        mask = $urandom() & ~32'h1;
        bus_write(REG_STS, mask, werr);
        bus_read(REG_STS, rd);
        check_eq("status after partial clear", rd, pins & ~mask);
        bus_write(REG_STS, '1, werr);
        wait_irq(1'b0, edges);
        check_eq("edges to irq fall", edges, 1);
        // Edge lands on the same edge as the clear
        j = $urandom() % GPIO_W;
        gpio_i = pins ^ (32'h1 << j);
        step(2);
        bus_write(REG_STS, '1, werr);
        bus_read(REG_STS, rd);
        check_eq("edge beats clear", rd, 32'h1 << j);
        finish_test("clear");

        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : gpio_tb

`default_nettype wire

// ==== flist.f ====
design/gpio_pkg.sv
design/gpio_bus_ctrl.sv
design/gpio_in_sync.sv
design/gpio_out_port.sv
design/gpio_irq_unit.sv
design/gpio_peri_top.sv
testbench/gpio_tb.sv

// ==== Bender.yml ====
package:
  name: gpio_peri

sources:
  - files:
      - design/gpio_pkg.sv
      - design/gpio_bus_ctrl.sv
      - design/gpio_in_sync.sv
      - design/gpio_out_port.sv
      - design/gpio_irq_unit.sv
      - design/gpio_peri_top.sv
  - target: simulation
    files:
      - testbench/gpio_tb.sv
